//--- dv/coupler_stim.txt
# W <word> writes a word, E <hi> <lo> expects a pair, B blocks reads until o_full
# T <name> names the pairs that follow, all values hex, lo is the earlier word
T backpressure
B
T pair_order
W 11111111
W 22222222
E 22222222 11111111
W 33333333
W 44444444
E 44444444 33333333
W a5a5a5a5
W 5a5a5a5a
E 5a5a5a5a a5a5a5a5
T zero_first
W 00000000
E 00000000 00000000
W 01234567
W 89abcdef
E 89abcdef 01234567
W 00000000
W 00000000
E 00000000 00000000
E 00000000 00000000
W cafef00d
W 00c0ffee
E 00c0ffee cafef00d
T zero_second
W 13572468
W 00000000
E 00000000 13572468
W deadbeef
W 00000000
E 00000000 deadbeef
T backpressure_fill
W 00000000
W 00000000
W 00000000
W 00000000
W 00000000
W 00000000
E 00000000 00000000
E 00000000 00000000
E 00000000 00000000
E 00000000 00000000
E 00000000 00000000
E 00000000 00000000
W a1000001
W a1000002
E a1000002 a1000001
W b2000003
W b2000004
E b2000004 b2000003
W c3000005
W c3000006
E c3000006 c3000005
W d4000007
W d4000008
E d4000008 d4000007
W e5000009
W e500000a
E e500000a e5000009
W f600000b
W f600000c
E f600000c f600000b
W 0700000d
W 0700000e
E 0700000e 0700000d
W 1800000f
W 18000010
E 18000010 1800000f
T mixed_random
W 0badf00d
W 00000000
E 00000000 0badf00d
W 00000000
E 00000000 00000000
W 76543210
W fedcba98
E fedcba98 76543210
W 00000000
E 00000000 00000000
W 00000001
W 80000000
E 80000000 00000001
W 600dcafe
W 00000000
E 00000000 600dcafe

//--- verilog.f
src/coupler_pkg.sv
src/word_fifo.sv
src/coupler.sv
src/coupler_top.sv
dv/coupler_tb.sv

//--- run.sh
#!/bin/sh
# builds the coupler testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module coupler_tb \
  -f verilog.f

# the simulation exits nonzero on a failed check, the log decides the result
./obj_dir/Vcoupler_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- dv/coupler_tb.sv
`timescale 1ns/1ps

module coupler_tb
  import coupler_pkg::*;
();

  localparam logic [31:0] SEED      = 32'd25575;
  localparam int          RESET_CYC = 5;

  // one entry of the write stream where a block entry holds reads off instead of writing
  typedef struct packed {
    logic  block;
    word_t word;
  } wr_rec_t;

  logic  clk = 1'b0;
  logic  rst_n;
  word_t in_data;
  logic  in_enq;
  logic  out_deq;
  pair_t out_data;
  logic  out_full;
  logic  out_empty;

  wr_rec_t wr_queue[$];
  pair_t   exp_queue[$];
  string   exp_names[$];
  int      rec_count;
  int      cycle_limit;
  int      cycles = 0;
  int      errors;
  logic    block_reads;

  coupler_top u_coupler_top (
    .i_clk   (clk),
    .i_rst_n (rst_n),
    .i_data  (in_data),
    .i_enq   (in_enq),
    .i_deq   (out_deq),
    .o_data  (out_data),
    .o_full  (out_full),
    .o_empty (out_empty)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles with %0d pairs still expected",
               cycles, exp_queue.size());
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped");
    end
  end

  // ************************************************************************
  // helpers
  // ************************************************************************

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic fail_run(input string why);
    errors++;
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_pair(input string name, input pair_t expected, input pair_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("Mismatch in %s: expected %h_%h, actual %h_%h", name,
                         expected.hi, expected.lo, actual.hi, actual.lo));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      fail_run($sformatf("Mismatch in %s: expected %b, actual %b", name, expected, actual));
    end
  endtask

  task automatic load_stimulus();
    int      fd;
    int      n;
    int      c;
    string   op;
    string   name;
    word_t   w_a;
    word_t   w_b;
    wr_rec_t rec;
    pair_t   exp_pair;
    name      = "unnamed";
    rec_count = 0;
    fd = $fopen("dv/coupler_stim.txt", "r");
    if (fd == 0) begin
      fail_run("cannot open the stimulus file dv/coupler_stim.txt");
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", op);
      if (n != 1) begin
        break;
      end
      if (op.substr(0, 0) == "#") begin
        c = $fgetc(fd);
        while (c != 10 && c != -1) begin  // rest of the comment line
          c = $fgetc(fd);
        end
      end else begin
        rec_count++;
        if (op == "W") begin
          n = $fscanf(fd, "%h", w_a);
          rec.block = 1'b0;
          rec.word  = w_a;
          wr_queue.push_back(rec);
        end else if (op == "E") begin
          n = $fscanf(fd, "%h %h", w_a, w_b) - 1;
          exp_pair.hi = w_a;
          exp_pair.lo = w_b;
          exp_queue.push_back(exp_pair);
          exp_names.push_back(name);
        end else if (op == "B") begin
          rec.block = 1'b1;
          rec.word  = '0;
          wr_queue.push_back(rec);
        end else if (op == "T") begin
          n = $fscanf(fd, "%s", name);
        end else begin
          fail_run($sformatf("unknown record %s in the stimulus file", op));
        end
        if (n != 1) begin
          fail_run($sformatf("record %s is missing its value in the stimulus file", op));
        end
      end
    end
    $fclose(fd);
  endtask

  // ************************************************************************
  // producer and consumer
  // ************************************************************************

  task automatic write_words();
    wr_rec_t rec;
    while (wr_queue.size() > 0) begin
      rec = wr_queue[0];
      if (rec.block) begin
        @(posedge clk);
        block_reads = 1'b1;
        #1;
        rec = wr_queue.pop_front();
      end else if (!out_full) begin
        rec     = wr_queue.pop_front();
        in_data = rec.word;
        in_enq  = 1'b1;
        @(posedge clk);
        #1;
        in_enq = 1'b0;
      end else begin
        @(posedge clk);  // the word waits while the input FIFO is full
        #1;
      end
    end
  endtask

  task automatic read_pairs();
    logic [31:0] rnd;
    pair_t       exp_pair;
    string       name;
    rnd = SEED;
    while (exp_queue.size() > 0) begin
      rnd = xorshift32(rnd);
      if (block_reads && out_full) begin
        // a full input side means the output FIFO is stuck full of pairs
        check_flag("backpressure o_empty", 1'b0, out_empty);
        block_reads = 1'b0;
      end
      if (!block_reads && !out_empty && rnd[1:0] != 2'b00) begin
        exp_pair = exp_queue.pop_front();
        name     = exp_names.pop_front();
        check_pair(name, exp_pair, out_data);
        out_deq = 1'b1;
      end else begin
        out_deq = 1'b0;
      end
      @(posedge clk);
      #1;
    end
    out_deq = 1'b0;
  endtask

  // ************************************************************************
  // main sequence
  // ************************************************************************

  initial begin
    rst_n       = 1'b0;
    in_data     = '0;
    in_enq      = 1'b0;
    out_deq     = 1'b0;
    block_reads = 1'b0;
    errors      = 0;
    cycle_limit = 200;
    load_stimulus();
    cycle_limit = 4 * rec_count + 200;

    repeat (RESET_CYC) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_flag("reset o_empty", 1'b1, out_empty);
    check_flag("reset o_full", 1'b0, out_full);

    fork
      write_words();
      read_pairs();
    join

    // a pair left over now would be a duplicate or a stray
    repeat (4) @(posedge clk);
    #1;
    check_flag("drain o_empty", 1'b1, out_empty);
    check_flag("drain o_full", 1'b0, out_full);

    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- src/coupler_top.sv
`timescale 1ns/1ps

module coupler_top
  import coupler_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_rst_n,
  input  word_t i_data,
  input  logic  i_enq,
  input  logic  i_deq,
  output pair_t o_data,
  output logic  o_full,
  output logic  o_empty
);

  word_t in_word;
  logic  in_empty;
  logic  in_deq;
  pair_t out_pair;
  logic  out_enq;
  logic  out_full;

  // ************************************************************************
  // input side, one word per entry
  // ************************************************************************

  word_fifo #(
    .DATA_W (WORD_W)
  ) u_in_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_data  (i_data),
    .i_enq   (i_enq),
    .i_deq   (in_deq),
    .o_data  (in_word),
    .o_full  (o_full),
    .o_empty (in_empty),
    .o_count ()
  );

  coupler u_coupler (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_in_word  (in_word),
    .i_in_empty (in_empty),
    .i_out_full (out_full),
    .o_in_deq   (in_deq),
    .o_out_pair (out_pair),
    .o_out_enq  (out_enq)
  );

  // output side holds whole pairs for the consumer
  word_fifo #(
    .DATA_W ($bits(pair_t))
  ) u_out_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_data  (out_pair),
    .i_enq   (out_enq),
    .i_deq   (i_deq),
    .o_data  (o_data),
    .o_full  (out_full),
    .o_empty (o_empty),
    .o_count ()
  );

endmodule

//--- src/coupler.sv
`timescale 1ns/1ps

module coupler
  import coupler_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_rst_n,
  input  word_t i_in_word,
  input  logic  i_in_empty,
  input  logic  i_out_full,
  output logic  o_in_deq,
  output pair_t o_out_pair,
  output logic  o_out_enq
);

  coupler_state_e state_q;
  coupler_state_e state_d;
  word_t          first_q;
  logic           capture;
  logic           marker;

  assign marker = (first_q == '0);  // held word ends a run

  // ************************************************************************
  // pairing FSM
  // ************************************************************************

  always_comb begin
    state_d   = state_q;
    capture   = 1'b0;
    o_in_deq  = 1'b0;
    o_out_enq = 1'b0;
    case (state_q)
      ST_FIRST: begin
        // only take a first word when the pair has somewhere to go
        if (!i_in_empty && !i_out_full) begin
          capture  = 1'b1;
          o_in_deq = 1'b1;
          state_d  = ST_SECOND;
        end
      end
      ST_SECOND: begin
        if (marker) begin
          if (!i_out_full) begin  // zero pair leaves the head in the FIFO
            o_out_enq = 1'b1;
            state_d   = ST_FIRST;
          end
        end else if (!i_in_empty && !i_out_full) begin
          o_out_enq = 1'b1;
          o_in_deq  = 1'b1;
          state_d   = ST_FIRST;
        end
      end
      default: begin
        state_d = ST_FIRST;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= ST_FIRST;
    end else begin
      state_q <= state_d;
    end
  end

  // first element of the pair
  always_ff @(posedge i_clk) begin
    if (capture) begin
      first_q <= i_in_word;
    end
  end

  // ************************************************************************
  // pair assembly
  // ************************************************************************

  // a marker pair carries zero in both halves
  assign o_out_pair.lo = first_q;
  assign o_out_pair.hi = marker ? '0 : i_in_word;

  // any strobe moves the FSM, so a full output must freeze it and the held word
  a_hold_while_full: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_out_full |=> $stable(state_q) && $stable(first_q)
  ) else $error("coupler moved on while the output FIFO was full");

  // only a marker pair may go out while the input FIFO has nothing to give
  a_wait_while_empty: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_in_empty && !(state_q == ST_SECOND && marker) |=> $stable(state_q)
  ) else $error("coupler consumed a word from an empty input FIFO");

endmodule

//--- src/word_fifo.sv
`timescale 1ns/1ps

module word_fifo
  import coupler_pkg::*;
#(
  parameter int DATA_W = WORD_W
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic [DATA_W-1:0] i_data,
  input  logic              i_enq,
  input  logic              i_deq,
  output logic [DATA_W-1:0] o_data,
  output logic              o_full,
  output logic              o_empty,
  output count_t            o_count
);

  logic [DATA_W-1:0] mem [FIFO_DEPTH];

  ptr_t   wr_ptr;
  ptr_t   rd_ptr;
  count_t count;
  logic   do_enq;
  logic   do_deq;

  function automatic ptr_t next_ptr(input ptr_t ptr);
    ptr_t nxt;
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + PTR_W'(1);
    end
    return nxt;
  endfunction

  // ************************************************************************
  // status
  // ************************************************************************

  assign o_full  = (count == CNT_W'(FIFO_DEPTH));
  assign o_empty = (count == '0);
  assign o_count = count;

  // strobes against a full or empty buffer are dropped here
  assign do_enq = i_enq & ~o_full;
  assign do_deq = i_deq & ~o_empty;

  // ************************************************************************
  // pointers and occupancy
  // ************************************************************************

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_enq) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_deq) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_enq, do_deq})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;  // both or neither leave it unchanged
      endcase
    end
  end

  // ************************************************************************
  // storage
  // ************************************************************************

  always_ff @(posedge i_clk) begin
    if (do_enq) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // show-ahead, the head entry is on the output while not empty
  assign o_data = mem[rd_ptr];

  // pointers and count must agree across wraps
  a_count_bound: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (count <= CNT_W'(FIFO_DEPTH)) &&
    ((count == '0 || count == CNT_W'(FIFO_DEPTH)) == (wr_ptr == rd_ptr))
  ) else $error("word_fifo occupancy out of range");

endmodule

//--- src/coupler_pkg.sv
package coupler_pkg;

  // ************************************************************************
  // widths and depths
  // ************************************************************************

  localparam int WORD_W     = 32;
  localparam int FIFO_DEPTH = 16;
  localparam int CNT_W      = 5;  // holds 0 through FIFO_DEPTH
  localparam int PTR_W      = 4;  // indexes FIFO_DEPTH entries

  // ************************************************************************
  // types
  // ************************************************************************

  // a zero word is the end-of-run marker
  typedef logic [WORD_W-1:0] word_t;

  typedef logic [CNT_W-1:0] count_t;

  typedef logic [PTR_W-1:0] ptr_t;

  // lo is the earlier word of the pair and hi the later one
  typedef struct packed {
    word_t hi;
    word_t lo;
  } pair_t;

  typedef enum logic {
    ST_FIRST,  // waiting for the first word
    ST_SECOND  // first word held in the register
  } coupler_state_e;

endpackage
